/* design/cpuPkg.sv */
/*
 * Shared types and sizes for the 16-bit multicycle core.
 * Opcode and ALU enum literals carry OP_ and ALU_ prefixes to keep them apart.
 * Immediates are zero-extended except the BRC offset, which is sign-extended.
 */
package cpuPkg;

	////////////////////////////////////////////////////////////
	// Sizes
	////////////////////////////////////////////////////////////
	localparam int DATA_W     = 16;               // Data and instruction word
	localparam int REG_CNT    = 8;
	localparam int REG_AW     = 3;                // log2(REG_CNT)
	localparam int DMEM_AW    = 6;
	localparam int DMEM_DEPTH = 1 << DMEM_AW;     // 64 words
	localparam int FLAG_W     = 3;

	// Flag bit positions, BRC mask uses the same order
	localparam int FLAG_Z = 0;
	localparam int FLAG_N = 1;
	localparam int FLAG_C = 2;

	////////////////////////////////////////////////////////////
	// Instruction fields
	////////////////////////////////////////////////////////////
	localparam int OPC_MSB  = 15;
	localparam int OPC_LSB  = 12;
	localparam int RD_MSB   = 11;                 // Also BRC condition mask
	localparam int RD_LSB   = 9;
	localparam int RS_MSB   = 8;
	localparam int RS_LSB   = 6;
	localparam int IMMF_BIT = 5;                  // ALU immediate select
	localparam int RT_MSB   = 2;
	localparam int RT_LSB   = 0;
	localparam int IMM5_MSB = 4;
	localparam int IMM5_LSB = 0;
	localparam int IMM8_MSB = 7;
	localparam int IMM8_LSB = 0;

	// Opcode map
	typedef enum logic [3:0] {
		OP_STR  = 4'b0000,
		OP_SWP  = 4'b0001,
		OP_BRC  = 4'b0010,
		OP_HLT  = 4'b0011,
		OP_RSV4 = 4'b0100,                    // No-op
		OP_LDR  = 4'b0101,
		OP_RSV6 = 4'b0110,                    // No-op
		OP_JLR  = 4'b0111,
		OP_ADD  = 4'b1000,
		OP_SUB  = 4'b1001,
		OP_LBI  = 4'b1010,
		OP_AND  = 4'b1011,
		OP_XOR  = 4'b1100,
		OP_SHL  = 4'b1101,
		OP_SHR  = 4'b1110,
		OP_SRA  = 4'b1111
	} opcodeT;

	// Matches opcode[2:0] of the 1xxx group
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_OR  = 3'd2,                       // LBI lands here
		ALU_AND = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SHL = 3'd5,
		ALU_SHR = 3'd6,
		ALU_SRA = 3'd7
	} aluOpT;

	typedef enum logic [1:0] {
		ST_FETCH,
		ST_EXEC,
		ST_MEMRD,
		ST_HALT
	} seqStateT;

endpackage

/* design/ctrlIf.sv */
/*
 * Decoded control bundle from the opcode decoder to its consumers.
 * Clock is carried only for checks inside the decoder.
 */
`timescale 1ns/1ns

interface ctrlIf (
	input logic i_clk
);

	cpuPkg::aluOpT aluOp;
	logic altSrc1;                            // Special source 1 (LBI, BRC)
	logic altSel;                             // 8-bit immediate as source 2
	logic useImm;                             // Force imm5
	logic allowImm;                           // imm5 if inst bit 5 set
	logic allowJmp;                           // BRC
	logic wrReg;
	logic wrCC;                               // Update flags
	logic isHlt;
	logic memRd;                              // LDR
	logic memWr;                              // STR
	logic isJlr;

	modport dec (
		input  i_clk,
		output aluOp, altSrc1, altSel, useImm, allowImm, allowJmp,
		output wrReg, wrCC, isHlt, memRd, memWr, isJlr
	);

	modport consumer (
		input aluOp, altSrc1, altSel, useImm, allowImm, allowJmp,
		input wrReg, wrCC, isHlt, memRd, memWr, isJlr
	);

endinterface

/* design/ctrlLogic.sv */
/*
 * Purely combinational opcode decoder, zero latency.
 * Reserved opcodes 0100 and 0110 decode to no writes, no jump.
 */
`timescale 1ns/1ns

module ctrlLogic (
	input cpuPkg::opcodeT i_opcode,
	ctrlIf.dec            ctrl
);

	////////////////////////////////////////////////////////////
	// Internal signals
	////////////////////////////////////////////////////////////
	logic [3:0] op;                           // Raw opcode bits
	logic       opX010;                       // LBI or BRC
	logic       opX101;                       // LDR or SHL
	logic       opX111;                       // JLR or SRA
	logic       opX000;                       // STR or ADD

	assign op = i_opcode;

	// Common opcode combos
	assign opX010 = ~op[2] &  op[1] & ~op[0];
	assign opX101 =  op[2] & ~op[1] &  op[0];
	assign opX111 =  op[2] &  op[1] &  op[0];
	assign opX000 = ~op[2] & ~op[1] & ~op[0];

	////////////////////////////////////////////////////////////
	// Control outputs
	////////////////////////////////////////////////////////////
	assign ctrl.aluOp    = cpuPkg::aluOpT'(op[2:0] & {3{op[3]}}); // 1bbb else ADD
	assign ctrl.altSrc1  = opX010;                       // LBI, BRC
	assign ctrl.altSel   = opX010;                       // LBI, BRC
	assign ctrl.useImm   = ~op[3] | (op[3] & opX010);    // 0xxx, LBI
	assign ctrl.allowImm =  op[3];                       // 1xxx
	assign ctrl.allowJmp = ~op[3] & opX010;              // BRC
	assign ctrl.wrReg    =  op[3] |                      // 1xxx
	                        (op[2] & op[0]) |            // LDR, JLR
	                        (~op[1] & op[0]);            // SWP
	assign ctrl.wrCC     =  op[3];                       // 1xxx
	assign ctrl.isHlt    = ~op[3] & ~op[2] & op[1] & op[0];

	// Memory and jump extensions
	assign ctrl.memRd = ~op[3] & opX101;                 // LDR
	assign ctrl.memWr = ~op[3] & opX000;                 // STR
	assign ctrl.isJlr = ~op[3] & opX111;                 // JLR

	// One RAM direction per instruction
	aMemExcl: assert property (@(posedge ctrl.i_clk) !(ctrl.memRd && ctrl.memWr))
		else $error("decoder raised memRd and memWr together");

endmodule

/* design/aluUnit.sv */
/*
 * 16-bit ALU with operand muxing, combinational.
 * Shift amount is the low 4 bits of source 2.
 * Carry is the ADD carry out or the SUB borrow, else 0.
 */
`timescale 1ns/1ns

module aluUnit (
	ctrlIf.consumer                    ctrl,
	input  logic [cpuPkg::DATA_W-1:0]  i_pc,
	input  logic [cpuPkg::DATA_W-1:0]  i_rsVal,
	input  logic [cpuPkg::DATA_W-1:0]  i_rtVal,
	input  logic [cpuPkg::DATA_W-1:0]  i_inst,
	output logic [cpuPkg::DATA_W-1:0]  o_result,
	output logic [cpuPkg::FLAG_W-1:0]  o_flags
);

	logic [cpuPkg::DATA_W-1:0] src1, src2;
	logic [cpuPkg::DATA_W-1:0] imm8Ext, imm5Ext;
	logic [cpuPkg::DATA_W:0]   addSum, subDiff;   // One extra bit for carry/borrow
	logic [3:0]                shAmt;
	logic                      carry;

	// Immediate extension
	assign imm8Ext = ctrl.allowJmp ?
		{{8{i_inst[cpuPkg::IMM8_MSB]}}, i_inst[cpuPkg::IMM8_MSB:cpuPkg::IMM8_LSB]} : // BRC
		{8'h00, i_inst[cpuPkg::IMM8_MSB:cpuPkg::IMM8_LSB]};                         // LBI
	assign imm5Ext = {11'd0, i_inst[cpuPkg::IMM5_MSB:cpuPkg::IMM5_LSB]};

	// Source 1 is PC+1 for BRC, zero for LBI
	assign src1 = !ctrl.altSrc1 ? i_rsVal :
		ctrl.allowJmp ? i_pc + 16'd1 : '0;

	always_comb begin
		if (ctrl.altSel)
			src2 = imm8Ext;
		else if (ctrl.useImm || (ctrl.allowImm && i_inst[cpuPkg::IMMF_BIT]))
			src2 = imm5Ext;
		else
			src2 = i_rtVal;                       // Register form
	end

	assign addSum  = {1'b0, src1} + {1'b0, src2};
	assign subDiff = {1'b0, src1} - {1'b0, src2};
	assign shAmt   = src2[3:0];

	////////////////////////////////////////////////////////////
	// Operation select
	////////////////////////////////////////////////////////////
	always_comb begin
		carry = 1'b0;
		case (ctrl.aluOp)
			cpuPkg::ALU_ADD: begin
				o_result = addSum[cpuPkg::DATA_W-1:0];
				carry    = addSum[cpuPkg::DATA_W];
			end
			cpuPkg::ALU_SUB: begin
				o_result = subDiff[cpuPkg::DATA_W-1:0];
				carry    = subDiff[cpuPkg::DATA_W];  // Borrow
			end
			cpuPkg::ALU_OR:  o_result = src1 | src2;
			cpuPkg::ALU_AND: o_result = src1 & src2;
			cpuPkg::ALU_XOR: o_result = src1 ^ src2;
			cpuPkg::ALU_SHL: o_result = src1 << shAmt;
			cpuPkg::ALU_SHR: o_result = src1 >> shAmt;
			default:         o_result = $signed(src1) >>> shAmt; // SRA
		endcase
	end

	assign o_flags[cpuPkg::FLAG_Z] = (o_result == '0);
	assign o_flags[cpuPkg::FLAG_N] = o_result[cpuPkg::DATA_W-1];
	assign o_flags[cpuPkg::FLAG_C] = carry;

endmodule

/* design/regFile.sv */
/*
 * 8 x 16 register file, two async read ports, one sync write port.
 * Reads return the old value in the write cycle, there is no bypass.
 */
`timescale 1ns/1ns

module regFile (
	input  logic                       i_clk,
	input  logic                       i_reset,
	input  logic [cpuPkg::REG_AW-1:0]  i_rdAddrA,
	input  logic [cpuPkg::REG_AW-1:0]  i_rdAddrB,
	output logic [cpuPkg::DATA_W-1:0]  o_rdDataA,
	output logic [cpuPkg::DATA_W-1:0]  o_rdDataB,
	input  logic                       i_wrEn,
	input  logic [cpuPkg::REG_AW-1:0]  i_wrAddr,
	input  logic [cpuPkg::DATA_W-1:0]  i_wrData
);

	logic [cpuPkg::DATA_W-1:0] regs [cpuPkg::REG_CNT];

	// Write port
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			for (int i = 0; i < cpuPkg::REG_CNT; i++) begin
				regs[i] <= '0;                    // All registers start at zero
			end
		end else if (i_wrEn) begin
			regs[i_wrAddr] <= i_wrData;
		end
	end

	// Read ports, zero latency
	assign o_rdDataA = regs[i_rdAddrA];
	assign o_rdDataB = regs[i_rdAddrB];

endmodule

/* design/dataRam.sv */
/*
 * 64-word data RAM, one cycle read latency.
 * Array has no reset; it only powers up cleared.
 */
`timescale 1ns/1ns

module dataRam (
	input  logic                       i_clk,
	input  logic                       i_rdEn,
	input  logic                       i_wrEn,
	input  logic [cpuPkg::DMEM_AW-1:0] i_addr,
	input  logic [cpuPkg::DATA_W-1:0]  i_wrData,
	output logic [cpuPkg::DATA_W-1:0]  o_rdData
);

	logic [cpuPkg::DATA_W-1:0] mem [cpuPkg::DMEM_DEPTH];

	// Power-up contents
	initial begin
		for (int i = 0; i < cpuPkg::DMEM_DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_wrEn)
			mem[i_addr] <= i_wrData;
		if (i_rdEn)
			o_rdData <= mem[i_addr];           // Registered read
	end

	aRdWrExcl: assert property (@(posedge i_clk) !(i_rdEn && i_wrEn))
		else $error("RAM read and write in the same cycle");

endmodule

/* design/coreSeq.sv */
/*
 * Fetch/execute sequencer with PC, instruction register and flags.
 * One instruction per fetch, committed at the end of EXEC; LDR adds MEMRD.
 * Fetch port holds valid and address until the handshake completes.
 * HLT parks in HALT until reset.
 */
`timescale 1ns/1ns

module coreSeq (
	input  logic                        i_clk,
	input  logic                        i_reset,
	ctrlIf.consumer                     ctrl,
	// Instruction fetch
	output logic                        o_fetchValid,
	input  logic                        i_fetchReady,
	output logic [cpuPkg::DATA_W-1:0]   o_fetchAddr,
	input  logic [cpuPkg::DATA_W-1:0]   i_fetchData,
	// Datapath
	output logic [cpuPkg::DATA_W-1:0]   o_inst,
	output logic [cpuPkg::DATA_W-1:0]   o_pc,
	input  logic [cpuPkg::DATA_W-1:0]   i_aluResult,
	input  logic [cpuPkg::FLAG_W-1:0]   i_aluFlags,
	input  logic [cpuPkg::DATA_W-1:0]   i_rsVal,
	input  logic [cpuPkg::DATA_W-1:0]   i_rdVal,
	// Register file write
	output logic                        o_rfWrEn,
	output logic [cpuPkg::REG_AW-1:0]   o_rfWrAddr,
	output logic [cpuPkg::DATA_W-1:0]   o_rfWrData,
	// Data RAM
	output logic                        o_ramRdEn,
	output logic                        o_ramWrEn,
	output logic [cpuPkg::DMEM_AW-1:0]  o_ramAddr,
	output logic [cpuPkg::DATA_W-1:0]   o_ramWrData,
	input  logic [cpuPkg::DATA_W-1:0]   i_ramRdData,
	// Observation
	output logic                        o_wbValid,
	output logic [cpuPkg::REG_AW-1:0]   o_wbReg,
	output logic [cpuPkg::DATA_W-1:0]   o_wbData,
	output logic                        o_halted
);

	cpuPkg::seqStateT           state;
	cpuPkg::opcodeT             opcode;
	logic [cpuPkg::DATA_W-1:0]  pc, pcPlus1, nextPc, wbData;
	logic [cpuPkg::DATA_W-1:0]  inst;
	logic [cpuPkg::FLAG_W-1:0]  flags;
	logic [cpuPkg::FLAG_W-1:0]  brMask;
	logic                       fetchXfer, inExec, inMemRd, brTaken;

	assign opcode  = cpuPkg::opcodeT'(inst[cpuPkg::OPC_MSB:cpuPkg::OPC_LSB]);
	assign brMask  = inst[cpuPkg::RD_MSB:cpuPkg::RD_LSB];
	assign pcPlus1 = pc + 16'd1;
	assign inExec  = (state == cpuPkg::ST_EXEC);
	assign inMemRd = (state == cpuPkg::ST_MEMRD);

	// Fetch handshake
	assign o_fetchValid = (state == cpuPkg::ST_FETCH);
	assign o_fetchAddr  = pc;
	assign fetchXfer    = o_fetchValid & i_fetchReady;

	////////////////////////////////////////////////////////////
	// Branch and next PC
	////////////////////////////////////////////////////////////
	assign brTaken = (brMask == '0) | (|(brMask & flags)); // 000 means always

	always_comb begin
		if (ctrl.allowJmp && brTaken)
			nextPc = i_aluResult;                 // PC+1 + sext(imm8)
		else if (ctrl.isJlr)
			nextPc = i_aluResult;                 // rs + imm5
		else
			nextPc = pcPlus1;
	end

	// Writeback source priority
	always_comb begin
		if (opcode == cpuPkg::OP_SWP)
			wbData = {i_rsVal[7:0], i_rsVal[15:8]};
		else if (ctrl.isJlr)
			wbData = pcPlus1;                     // Link value
		else if (inMemRd)
			wbData = i_ramRdData;
		else
			wbData = i_aluResult;
	end

	////////////////////////////////////////////////////////////
	// State, PC, IR, flags
	////////////////////////////////////////////////////////////
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state <= cpuPkg::ST_FETCH;
			pc    <= '0;
			flags <= '0;
			inst  <= '0;
		end else begin
			case (state)
				cpuPkg::ST_FETCH: begin
					if (fetchXfer) begin
						inst  <= i_fetchData;
						state <= cpuPkg::ST_EXEC;
					end
				end
				cpuPkg::ST_EXEC: begin
					if (ctrl.isHlt) begin
						state <= cpuPkg::ST_HALT;     // PC stays on the HLT
					end else begin
						pc <= nextPc;
						if (ctrl.wrCC)
							flags <= i_aluFlags;
						state <= ctrl.memRd ? cpuPkg::ST_MEMRD : cpuPkg::ST_FETCH;
					end
				end
				cpuPkg::ST_MEMRD: state <= cpuPkg::ST_FETCH; // RAM data lands now
				default:          state <= cpuPkg::ST_HALT;
			endcase
		end
	end

	// Register write, LDR deferred one cycle
	assign o_rfWrEn   = (inExec & ctrl.wrReg & ~ctrl.memRd) | inMemRd;
	assign o_rfWrAddr = inst[cpuPkg::RD_MSB:cpuPkg::RD_LSB];
	assign o_rfWrData = wbData;

	// RAM access in EXEC, address from ALU (rs + imm5)
	assign o_ramRdEn   = inExec & ctrl.memRd;
	assign o_ramWrEn   = inExec & ctrl.memWr;
	assign o_ramAddr   = i_aluResult[cpuPkg::DMEM_AW-1:0];
	assign o_ramWrData = i_rdVal;

	assign o_wbValid = o_rfWrEn;
	assign o_wbReg   = o_rfWrAddr;
	assign o_wbData  = wbData;
	assign o_halted  = (state == cpuPkg::ST_HALT);
	assign o_inst    = inst;
	assign o_pc      = pc;

	// Request held under back-pressure
	aFetchHold: assert property (@(posedge i_clk) disable iff (i_reset)
		o_fetchValid && !i_fetchReady |=> o_fetchValid && $stable(o_fetchAddr))
		else $error("fetch request dropped or moved before handshake");

endmodule

/* design/cpuTop.sv */
/*
 * Multicycle 16-bit core top level.
 * Instruction memory is external on the fetch port; data RAM is internal.
 * Every register write is mirrored on the writeback port, no ready.
 */
`timescale 1ns/1ns

module cpuTop (
	input  logic                       i_clk,
	input  logic                       i_reset,
	output logic                       o_fetchValid,
	input  logic                       i_fetchReady,
	output logic [cpuPkg::DATA_W-1:0]  o_fetchAddr,
	input  logic [cpuPkg::DATA_W-1:0]  i_fetchData,
	output logic                       o_wbValid,
	output logic [cpuPkg::REG_AW-1:0]  o_wbReg,
	output logic [cpuPkg::DATA_W-1:0]  o_wbData,
	output logic                       o_halted
);

	logic [cpuPkg::DATA_W-1:0]  inst, pc, aluResult;
	logic [cpuPkg::FLAG_W-1:0]  aluFlags;
	logic [cpuPkg::DATA_W-1:0]  rdDataA, rdDataB;
	logic [cpuPkg::REG_AW-1:0]  rdAddrB, rfWrAddr;
	logic [cpuPkg::DATA_W-1:0]  rfWrData, ramWrData, ramRdData;
	logic [cpuPkg::DMEM_AW-1:0] ramAddr;
	logic                       rfWrEn, ramRdEn, ramWrEn;
	cpuPkg::opcodeT             opcode;

	assign opcode = cpuPkg::opcodeT'(inst[cpuPkg::OPC_MSB:cpuPkg::OPC_LSB]);

	// Port B reads rd for STR data, rt otherwise
	assign rdAddrB = (opcode == cpuPkg::OP_STR) ?
		inst[cpuPkg::RD_MSB:cpuPkg::RD_LSB] : inst[cpuPkg::RT_MSB:cpuPkg::RT_LSB];

	////////////////////////////////////////////////////////////
	// Blocks
	////////////////////////////////////////////////////////////
	ctrlIf ctrl (.i_clk(i_clk));

	ctrlLogic uDec (.i_opcode(opcode), .ctrl(ctrl.dec));

	aluUnit uAlu (
		.ctrl(ctrl.consumer), .i_pc(pc), .i_rsVal(rdDataA), .i_rtVal(rdDataB),
		.i_inst(inst), .o_result(aluResult), .o_flags(aluFlags)
	);

	regFile uRegs (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_rdAddrA(inst[cpuPkg::RS_MSB:cpuPkg::RS_LSB]), .i_rdAddrB(rdAddrB),
		.o_rdDataA(rdDataA), .o_rdDataB(rdDataB),
		.i_wrEn(rfWrEn), .i_wrAddr(rfWrAddr), .i_wrData(rfWrData)
	);

	dataRam uRam (
		.i_clk(i_clk), .i_rdEn(ramRdEn), .i_wrEn(ramWrEn), .i_addr(ramAddr),
		.i_wrData(ramWrData), .o_rdData(ramRdData)
	);

	coreSeq uSeq (
		.i_clk(i_clk), .i_reset(i_reset), .ctrl(ctrl.consumer),
		.o_fetchValid(o_fetchValid), .i_fetchReady(i_fetchReady),
		.o_fetchAddr(o_fetchAddr), .i_fetchData(i_fetchData),
		.o_inst(inst), .o_pc(pc), .i_aluResult(aluResult), .i_aluFlags(aluFlags),
		.i_rsVal(rdDataA), .i_rdVal(rdDataB),
		.o_rfWrEn(rfWrEn), .o_rfWrAddr(rfWrAddr), .o_rfWrData(rfWrData),
		.o_ramRdEn(ramRdEn), .o_ramWrEn(ramWrEn), .o_ramAddr(ramAddr),
		.o_ramWrData(ramWrData), .i_ramRdData(ramRdData),
		.o_wbValid(o_wbValid), .o_wbReg(o_wbReg), .o_wbData(o_wbData),
		.o_halted(o_halted)
	);

endmodule

/* tb/cpuTb.sv */
/*
 * Testbench for cpuTop with a random 64-word program and an ISA model.
 * Control flow is forward only (BRC and JLR), so every run ends on the HLT at word 63.
 * RAM accesses go through base r6 (addresses 0..7). r7 holds JLR targets.
 * Random ops never write r6 or r7.
 */
`timescale 1ns/1ns

module cpuTb;

	logic                       clk;
	logic                       reset;
	logic                       fetchValid, fetchReady;
	logic [cpuPkg::DATA_W-1:0]  fetchAddr, fetchData;
	logic                       wbValid;
	logic [cpuPkg::REG_AW-1:0]  wbReg;
	logic [cpuPkg::DATA_W-1:0]  wbData;
	logic                       halted;

	integer                     seed;
	int                         wbErrors, fetchErrors, ctrlErrors;
	logic [cpuPkg::DATA_W-1:0]  prog [64];                  // Instruction memory
	logic                       jlrSlot [64];               // JLR word of an LBI/JLR pair
	logic [cpuPkg::DATA_W-1:0]  modelRegs [cpuPkg::REG_CNT];
	logic [cpuPkg::DATA_W-1:0]  modelRam [cpuPkg::DMEM_DEPTH];
	logic [cpuPkg::REG_AW-1:0]  expWbReg [$];
	logic [cpuPkg::DATA_W-1:0]  expWbData [$];
	logic [cpuPkg::DATA_W-1:0]  expFetch [$];               // Model fetch order
	logic                       holdPending;                // Valid seen without ready
	logic [cpuPkg::DATA_W-1:0]  heldAddr;
	logic                       timedOut;

	cpuTop dut (
		.i_clk(clk), .i_reset(reset),
		.o_fetchValid(fetchValid), .i_fetchReady(fetchReady),
		.o_fetchAddr(fetchAddr), .i_fetchData(fetchData),
		.o_wbValid(wbValid), .o_wbReg(wbReg), .o_wbData(wbData),
		.o_halted(halted)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;                                   // 10 ns period

	function automatic int randBelow(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	////////////////////////////////////////////////////////////
	// Program generation
	////////////////////////////////////////////////////////////
	task automatic buildProgram();
		int i, pick, off, t;
		logic isLoad;
		cpuPkg::opcodeT opc;
		for (int w = 0; w < 64; w++) begin
			prog[w]    = '0;
			jlrSlot[w] = 1'b0;
		end
		i = 0;
		while (i < 63) begin
			pick = randBelow(16);
			if (i <= 61 && pick < 3) begin
				// LBI r6 with address, then STR or LDR at r6 + 0
				isLoad = (i >= 16) && (randBelow(2) == 1);  // Only stores early on
				prog[i] = {cpuPkg::OP_LBI, 3'd6, 1'b0, 8'(randBelow(8))};
				if (isLoad)
					prog[i+1] = {cpuPkg::OP_LDR, 3'(randBelow(6)), 3'd6, 6'd0};
				else
					prog[i+1] = {cpuPkg::OP_STR, 3'(randBelow(8)), 3'd6, 6'd0};
				i += 2;
			end else if (i <= 61 && pick == 3) begin
				t = i + 2 + randBelow(6);                   // Forward target
				if (t > 63)
					t = 63;
				prog[i]      = {cpuPkg::OP_LBI, 3'd7, 1'b0, 8'(t)};
				prog[i+1]    = {cpuPkg::OP_JLR, 3'(randBelow(6)), 3'd7, 6'd0};
				jlrSlot[i+1] = 1'b1;
				i += 2;
			end else begin
				pick = randBelow(12);
				case (pick)
					0:       opc = cpuPkg::OP_SWP;
					1:       opc = cpuPkg::OP_BRC;
					2:       opc = cpuPkg::OP_RSV4;
					3:       opc = cpuPkg::OP_RSV6;
					default: opc = cpuPkg::opcodeT'(4'(pick + 4)); // ADD..SRA
				endcase
				prog[i] = {opc, 3'(randBelow(6)), 9'(randBelow(512))};
				if (opc == cpuPkg::OP_BRC) begin
					off = randBelow(7) + 1;
					if (i + 1 + off > 63)
						off = 62 - i;                       // Land on HLT at most
					prog[i] = {cpuPkg::OP_BRC, 3'(randBelow(8)), 1'b0, 8'(off)};
				end
				i += 1;
			end
		end
		prog[63] = {cpuPkg::OP_HLT, 12'd0};

		// Landing on a JLR word skips its LBI, so move such targets back by one
		for (int j = 0; j < 63; j++) begin
			if (prog[j][15:12] == cpuPkg::OP_BRC) begin
				t = j + 1 + int'(prog[j][7:0]);
				if (jlrSlot[t])
					prog[j][7:0] = 8'(t - j - 2);
			end else if (jlrSlot[j+1]) begin
				t = int'(prog[j][7:0]);                     // LBI r7 target
				if (jlrSlot[t])
					prog[j][7:0] = 8'(t - 1);
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// ISA model
	////////////////////////////////////////////////////////////
	task automatic recordWrite(input logic [cpuPkg::REG_AW-1:0] rd,
		input logic [cpuPkg::DATA_W-1:0] val);
		expWbReg.push_back(rd);
		expWbData.push_back(val);
		modelRegs[rd] = val;
	endtask

	task automatic runModel();
		logic [cpuPkg::DATA_W-1:0] pc, nextPc, inst, a, b, res, imm5, addr;
		logic [cpuPkg::DATA_W:0]   wide;
		logic [cpuPkg::FLAG_W-1:0] flags;
		logic [cpuPkg::REG_AW-1:0] rd;
		cpuPkg::opcodeT            op;
		logic                      c, done;
		int                        steps;
		for (int r = 0; r < cpuPkg::REG_CNT; r++) begin
			modelRegs[r] = '0;
		end
		for (int m = 0; m < cpuPkg::DMEM_DEPTH; m++) begin
			modelRam[m] = '0;
		end
		pc    = '0;
		flags = '0;
		done  = 1'b0;
		steps = 0;
		while (!done && steps < 1000) begin
			steps++;
			expFetch.push_back(pc);
			inst   = prog[pc[5:0]];
			op     = cpuPkg::opcodeT'(inst[15:12]);
			rd     = inst[11:9];                            // Also BRC mask
			a      = modelRegs[inst[8:6]];
			imm5   = {11'd0, inst[4:0]};
			b      = inst[5] ? imm5 : modelRegs[inst[2:0]];
			addr   = a + imm5;                              // LDR, STR, JLR
			nextPc = pc + 16'd1;
			c      = 1'b0;
			res    = '0;
			if (inst[15]) begin
				case (op)
					cpuPkg::OP_ADD: begin
						wide = {1'b0, a} + {1'b0, b};
						res  = wide[15:0];
						c    = wide[16];
					end
					cpuPkg::OP_SUB: begin
						res = a - b;
						c   = (a < b);                      // Borrow
					end
					cpuPkg::OP_LBI: res = {8'h00, inst[7:0]};
					cpuPkg::OP_AND: res = a & b;
					cpuPkg::OP_XOR: res = a ^ b;
					cpuPkg::OP_SHL: res = a << b[3:0];
					cpuPkg::OP_SHR: res = a >> b[3:0];
					default:        res = $signed(a) >>> b[3:0];
				endcase
				recordWrite(rd, res);
				flags[cpuPkg::FLAG_Z] = (res == '0);
				flags[cpuPkg::FLAG_N] = res[15];
				flags[cpuPkg::FLAG_C] = c;
			end else begin
				case (op)
					cpuPkg::OP_STR: modelRam[addr[5:0]] = modelRegs[rd];
					cpuPkg::OP_SWP: recordWrite(rd, {a[7:0], a[15:8]});
					cpuPkg::OP_BRC: begin
						if (rd == 3'd0 || (rd & flags) != 3'd0)
							nextPc = pc + 16'd1 + {{8{inst[7]}}, inst[7:0]};
					end
					cpuPkg::OP_HLT: done = 1'b1;
					cpuPkg::OP_LDR: recordWrite(rd, modelRam[addr[5:0]]);
					cpuPkg::OP_JLR: begin
						nextPc = addr;                      // Old rs value
						recordWrite(rd, pc + 16'd1);
					end
					default: ;                              // Reserved
				endcase
			end
			pc = nextPc;
		end
		if (!done) begin
			$display("Model did not reach HLT within 1000 steps");
			ctrlErrors++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////
	task automatic checkWb(input logic [cpuPkg::REG_AW-1:0] gotReg,
		input logic [cpuPkg::DATA_W-1:0] gotData);
		logic [cpuPkg::REG_AW-1:0] expReg;
		logic [cpuPkg::DATA_W-1:0] expData;
		if (expWbReg.size() == 0) begin
			$display("Writeback to r%0d at %0t ns with no write left in the model",
				gotReg, $time);
			wbErrors++;
		end else begin
			expReg  = expWbReg.pop_front();
			expData = expWbData.pop_front();
			if (gotReg !== expReg) begin
				$display("FAIL at %0t ns: o_wbReg got %0d expected %0d", $time, gotReg, expReg);
				wbErrors++;
			end
			if (gotData !== expData) begin
				$display("FAIL at %0t ns: o_wbData got %h expected %h", $time, gotData, expData);
				wbErrors++;
			end
		end
	endtask

	task automatic checkAddr(input logic [cpuPkg::DATA_W-1:0] got,
		input logic [cpuPkg::DATA_W-1:0] exp);
		if (got !== exp) begin
			$display("FAIL at %0t ns: o_fetchAddr got %h expected %h", $time, got, exp);
			fetchErrors++;
		end
	endtask

	task automatic checkHalt(input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAIL at %0t ns: o_halted got %b expected %b", $time, got, exp);
			ctrlErrors++;
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAIL at %0t ns: %s got %b expected %b", $time, name, got, exp);
			ctrlErrors++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Per-cycle work, all on the falling edge
	////////////////////////////////////////////////////////////
	task automatic sampleOutputs();
		if (holdPending) begin
			if (fetchValid !== 1'b1) begin
				$display("Fetch request dropped at %0t ns before the handshake", $time);
				fetchErrors++;
			end else begin
				checkAddr(fetchAddr, heldAddr);             // Must not move
			end
		end
		if (wbValid === 1'b1)
			checkWb(wbReg, wbData);
	endtask

	task automatic driveInputs();
		fetchReady  = (randBelow(2) == 1);                  // 50% back-pressure
		fetchData   = prog[fetchAddr[5:0]];
		holdPending = fetchValid && !fetchReady;
		heldAddr    = fetchAddr;
		if (fetchValid && fetchReady) begin
			// Transfer on the next rising edge
			if (expFetch.size() == 0) begin
				$display("Fetch of address %h at %0t ns after the model finished",
					fetchAddr, $time);
				fetchErrors++;
			end else begin
				checkAddr(fetchAddr, expFetch.pop_front());
			end
		end
	endtask

	task automatic stepCycle();
		@(negedge clk);
		sampleOutputs();
		driveInputs();
	endtask

	task automatic waitHalt();
		int n;
		n = 0;
		while (halted !== 1'b1 && n < 2000) begin
			stepCycle();
			n++;
		end
		if (halted !== 1'b1) begin
			$display("Timeout after 2000 cycles waiting for o_halted");
			ctrlErrors++;
			timedOut = 1'b1;
		end
	endtask

	task automatic finishRun();
		$display("Errors: writeback %0d, fetch %0d, control %0d",
			wbErrors, fetchErrors, ctrlErrors);
		if (wbErrors + fetchErrors + ctrlErrors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////
	initial begin
		seed        = 32'ha5f4;
		wbErrors    = 0;
		fetchErrors = 0;
		ctrlErrors  = 0;
		reset       = 1'b1;
		fetchReady  = 1'b0;
		fetchData   = '0;
		holdPending = 1'b0;
		heldAddr    = '0;
		timedOut    = 1'b0;
		buildProgram();
		runModel();

		repeat (5) @(negedge clk);                          // 5 reset cycles
		reset = 1'b0;
		checkBit("o_fetchValid", fetchValid, 1'b1);         // Request from the first cycle
		checkBit("o_wbValid", wbValid, 1'b0);
		checkHalt(halted, 1'b0);
		driveInputs();

		waitHalt();
		if (!timedOut) begin
			if (expWbReg.size() != 0) begin
				$display("Halted with %0d model writebacks never seen", expWbReg.size());
				wbErrors++;
			end
			if (expFetch.size() != 0) begin
				$display("Halted with %0d model fetches never seen", expFetch.size());
				fetchErrors++;
			end
			// Quiet after HLT
			repeat (50) begin
				stepCycle();
				checkHalt(halted, 1'b1);
				checkBit("o_fetchValid", fetchValid, 1'b0);
			end
		end
		finishRun();
	end

endmodule

/* build.f */
design/cpuPkg.sv
design/ctrlIf.sv
design/ctrlLogic.sv
design/aluUnit.sv
design/regFile.sv
design/dataRam.sv
design/coreSeq.sv
design/cpuTop.sv
tb/cpuTb.sv

/* run.sh */
#!/bin/sh
# Compile the testbench and the core with Verilator, run it, judge the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module cpuTb -f build.f \
	--Mdir obj_dir -o cpuSim

# The simulator status is ignored here; the log decides
./obj_dir/cpuSim | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
	echo "Result: PASS"
	exit 0
fi
echo "Result: FAIL"
exit 1
